/* design/mips_ctrl_consts.svh */
`ifndef MIPS_CTRL_CONSTS_SVH
`define MIPS_CTRL_CONSTS_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// External step counter
`define STEP_W 3

// Step values that release each group of states
`define STEP_FETCH 3'd1
`define STEP_DECODE 3'd2
`define STEP_EXEC 3'd3
`define STEP_MEM 3'd4
`define STEP_DONE 3'd5

// Opcode encodings
`define OPC_RTYPE 6'h00
`define OPC_J 6'h02
`define OPC_JAL 6'h03
`define OPC_BEQ 6'h04
`define OPC_BNE 6'h05
`define OPC_ADDI 6'h08
`define OPC_SLTI 6'h0A
`define OPC_ANDI 6'h0C
`define OPC_ORI 6'h0D
`define OPC_LUI 6'h0F
`define OPC_LW 6'h23
`define OPC_SW 6'h2B

// Funct encodings for R-type
`define FNC_JR 6'h08
`define FNC_ADD 6'h20
`define FNC_SUB 6'h22
`define FNC_AND 6'h24
`define FNC_OR 6'h25
`define FNC_SLT 6'h2A

`endif

/* design/mips_ctrl_pkg.sv */
`include "mips_ctrl_consts.svh"

package mips_ctrl_pkg;

    // Sequencer states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_WRITE_BACK,
        ST_EFF_ADDR,
        ST_STORE,
        ST_LOAD,
        ST_BRANCH_ADDR,
        ST_BEQ_CMP,
        ST_BNE_CMP,
        ST_JUMP,
        ST_UPDATE_PC,
        ST_WAIT,
        ST_UNDEFINED
    } ctrl_state_t;

    // Supported opcodes
    typedef enum logic [`OPCODE_W-1:0] {
        OP_RTYPE = `OPC_RTYPE,
        OP_J     = `OPC_J,
        OP_JAL   = `OPC_JAL,
        OP_BEQ   = `OPC_BEQ,
        OP_BNE   = `OPC_BNE,
        OP_ADDI  = `OPC_ADDI,
        OP_SLTI  = `OPC_SLTI,
        OP_ANDI  = `OPC_ANDI,
        OP_ORI   = `OPC_ORI,
        OP_LUI   = `OPC_LUI,
        OP_LW    = `OPC_LW,
        OP_SW    = `OPC_SW
    } opcode_t;

    // Supported R-type funct codes
    typedef enum logic [`FUNCT_W-1:0] {
        FN_JR  = `FNC_JR,
        FN_ADD = `FNC_ADD,
        FN_SUB = `FNC_SUB,
        FN_AND = `FNC_AND,
        FN_OR  = `FNC_OR,
        FN_SLT = `FNC_SLT
    } funct_t;

    // ALU operation, encoding matches the datapath ALU
    typedef enum logic [3:0] {
        ALU_AND = 4'd0,
        ALU_SUB = 4'd1,
        ALU_ADD = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_LUI = 4'd5
    } alu_op_t;

    // Path chosen after decode
    typedef enum logic [2:0] {IC_ALU, IC_MEM, IC_BRANCH, IC_JUMP, IC_BAD} instr_class_t;

    // Datapath mux selectors
    typedef enum logic [1:0] {
        SRC_B_REG       = 2'd0,
        SRC_B_FOUR      = 2'd1,
        SRC_B_IMM       = 2'd2,
        SRC_B_IMM_SHIFT = 2'd3
    } src_b_t;
    typedef enum logic {SRC_A_PC, SRC_A_REG} src_a_t;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} reg_dst_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC} wb_src_t;
    typedef enum logic {PC_ALU_RESULT, PC_ALU_OUT} pc_src_t;
    typedef enum logic [1:0] {JMP_NONE, JMP_DIRECT, JMP_REG, JMP_LINK} jump_kind_t;

endpackage

/* design/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder
    import mips_ctrl_pkg::*;
(
    input  opcode_t      opcode,
    input  funct_t       funct,
    output instr_class_t instr_class,
    output logic         is_store,
    output alu_op_t      alu_op_dec,
    output src_b_t       src_b_dec,
    output reg_dst_t     reg_dst_dec,
    output logic         link,
    output jump_kind_t   jump_kind
);

    always_comb
    begin
        // Anything not matched below is an undefined instruction
        instr_class = IC_BAD;
        is_store    = 1'b0;
        alu_op_dec  = ALU_AND;
        src_b_dec   = SRC_B_REG;
        reg_dst_dec = DST_RT;
        link        = 1'b0;
        jump_kind   = JMP_NONE;

        case (opcode)
            OP_RTYPE:
            begin
                // Register operands, result to rd
                instr_class = IC_ALU;
                src_b_dec   = SRC_B_REG;
                reg_dst_dec = DST_RD;
                case (funct)
                    FN_ADD: alu_op_dec = ALU_ADD;
                    FN_SUB: alu_op_dec = ALU_SUB;
                    FN_AND: alu_op_dec = ALU_AND;
                    FN_OR:  alu_op_dec = ALU_OR;
                    FN_SLT: alu_op_dec = ALU_SLT;
                    FN_JR:
                    begin
                        // jr goes down the jump path with the register target
                        instr_class = IC_JUMP;
                        jump_kind   = JMP_REG;
                    end
                    default: instr_class = IC_BAD;
                endcase
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI:
            begin
                // Immediate ALU group, result to rt
                instr_class = IC_ALU;
                src_b_dec   = SRC_B_IMM;
                reg_dst_dec = DST_RT;
                case (opcode)
                    OP_ADDI: alu_op_dec = ALU_ADD;
                    OP_SLTI: alu_op_dec = ALU_SLT;
                    OP_ANDI: alu_op_dec = ALU_AND;
                    OP_ORI:  alu_op_dec = ALU_OR;
                    default: alu_op_dec = ALU_LUI;
                endcase
            end
            OP_LW, OP_SW:
            begin
                // Base plus offset address
                instr_class = IC_MEM;
                alu_op_dec  = ALU_ADD;
                src_b_dec   = SRC_B_IMM;
                reg_dst_dec = DST_RT;
                is_store    = (opcode == OP_SW);
            end
            OP_BEQ, OP_BNE:
            begin
                // Compare by subtraction, zero flag decides
                instr_class = IC_BRANCH;
                alu_op_dec  = ALU_SUB;
            end
            OP_J:
            begin
                instr_class = IC_JUMP;
                jump_kind   = JMP_DIRECT;
            end
            OP_JAL:
            begin
                // Return address goes to ra
                instr_class = IC_JUMP;
                jump_kind   = JMP_LINK;
                reg_dst_dec = DST_RA;
                link        = 1'b1;
            end
            default:
            begin
                instr_class = IC_BAD;
            end
        endcase
    end

endmodule

/* design/ctrl_fsm.sv */
`timescale 1ns/10ps
`include "mips_ctrl_consts.svh"

module ctrl_fsm
    import mips_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [`STEP_W-1:0] step,
    input  instr_class_t       instr_class,
    input  logic               is_store,
    input  opcode_t            opcode,
    output ctrl_state_t        state
);

    // Step value the current state waits for
    logic [`STEP_W-1:0] wait_step;
    // Where the state goes once released
    ctrl_state_t        target;
    ctrl_state_t        state_next;

    always_comb
    begin
        wait_step = `STEP_FETCH;
        target    = ST_IDLE;

        case (state)
            ST_IDLE, ST_WAIT:
            begin
                wait_step = `STEP_FETCH;
                target    = ST_FETCH;
            end
            ST_FETCH:
            begin
                wait_step = `STEP_DECODE;
                target    = ST_DECODE;
            end
            ST_DECODE:
            begin
                // Dispatch on the decoded class
                wait_step = `STEP_EXEC;
                case (instr_class)
                    IC_ALU:    target = ST_EXECUTE;
                    IC_MEM:    target = ST_EFF_ADDR;
                    IC_BRANCH: target = ST_BRANCH_ADDR;
                    IC_JUMP:   target = ST_JUMP;
                    default:   target = ST_UNDEFINED;
                endcase
            end
            ST_EXECUTE:
            begin
                wait_step = `STEP_MEM;
                target    = ST_WRITE_BACK;
            end
            ST_EFF_ADDR:
            begin
                wait_step = `STEP_MEM;
                target    = is_store ? ST_STORE : ST_LOAD;
            end
            ST_BRANCH_ADDR:
            begin
                // beq and bne differ only in the compare state
                wait_step = `STEP_MEM;
                case (opcode)
                    OP_BEQ:  target = ST_BEQ_CMP;
                    OP_BNE:  target = ST_BNE_CMP;
                    default: target = ST_UNDEFINED;
                endcase
            end
            ST_JUMP:
            begin
                wait_step = `STEP_MEM;
                target    = ST_UPDATE_PC;
            end
            ST_WRITE_BACK, ST_STORE, ST_LOAD, ST_BEQ_CMP, ST_BNE_CMP, ST_UPDATE_PC:
            begin
                // Final states of every path park in WAIT
                wait_step = `STEP_DONE;
                target    = ST_WAIT;
            end
            default:
            begin
                // UNDEFINED and unused codes fall back to IDLE
                wait_step = `STEP_FETCH;
                target    = ST_IDLE;
            end
        endcase
    end

    // Hold until the awaited step, UNDEFINED leaves unconditionally
    always_comb
    begin
        if (state == ST_UNDEFINED || step == wait_step)
            state_next = target;
        else
            state_next = state;
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

endmodule

/* design/ctrl_outputs.sv */
`timescale 1ns/10ps

module ctrl_outputs
    import mips_ctrl_pkg::*;
(
    input  ctrl_state_t state,
    input  logic        zero,
    input  alu_op_t     alu_op_dec,
    input  src_b_t      src_b_dec,
    input  reg_dst_t    reg_dst_dec,
    input  logic        link,
    output logic        i_or_d,
    output logic        mem_write,
    output logic        mem_select,
    output logic        ir_write,
    output logic        data_write,
    output logic        reg_write,
    output logic        rdx_en,
    output logic        alu_result_en,
    output logic        pc_write,
    output logic        branch,
    output logic        pc_en,
    output alu_op_t     alu_control,
    output src_a_t      src_a,
    output src_b_t      src_b,
    output reg_dst_t    reg_dst,
    output wb_src_t     mem_to_reg,
    output pc_src_t     pc_src
);

    always_comb
    begin
        // Everything inactive unless the state asks for it
        i_or_d        = 1'b0;
        mem_write     = 1'b0;
        mem_select    = 1'b0;
        ir_write      = 1'b0;
        data_write    = 1'b0;
        reg_write     = 1'b0;
        rdx_en        = 1'b0;
        alu_result_en = 1'b0;
        pc_write      = 1'b0;
        branch        = 1'b0;
        alu_control   = ALU_AND;
        src_a         = SRC_A_PC;
        src_b         = SRC_B_REG;
        reg_dst       = DST_RT;
        mem_to_reg    = WB_ALU;
        pc_src        = PC_ALU_RESULT;

        case (state)
            ST_FETCH, ST_UPDATE_PC:
            begin
                // Instruction register load and pc + 4
                ir_write    = 1'b1;
                src_b       = SRC_B_FOUR;
                alu_control = ALU_ADD;
                src_a       = SRC_A_PC;
                // UPDATE_PC only prepares the sum and leaves pc alone
                pc_write    = (state == ST_FETCH);
            end
            ST_DECODE:
            begin
                // Latch register file reads
                rdx_en      = 1'b1;
                src_a       = SRC_A_REG;
                reg_dst     = reg_dst_dec;
                alu_control = alu_op_dec;
            end
            ST_EXECUTE:
            begin
                alu_result_en = 1'b1;
                src_a         = SRC_A_REG;
                src_b         = src_b_dec;
                alu_control   = alu_op_dec;
                reg_dst       = reg_dst_dec;
            end
            ST_WRITE_BACK:
            begin
                reg_write  = 1'b1;
                reg_dst    = reg_dst_dec;
                mem_to_reg = WB_ALU;
            end
            ST_EFF_ADDR:
            begin
                // Base register plus sign extended offset
                rdx_en        = 1'b1;
                alu_result_en = 1'b1;
                src_a         = SRC_A_REG;
                src_b         = SRC_B_IMM;
                alu_control   = ALU_ADD;
            end
            ST_STORE:
            begin
                // Data memory write at ALU out
                i_or_d     = 1'b1;
                mem_write  = 1'b1;
                mem_select = 1'b1;
            end
            ST_LOAD:
            begin
                // Memory read straight into the register file
                i_or_d     = 1'b1;
                mem_select = 1'b1;
                data_write = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = WB_MEM;
                reg_dst    = reg_dst_dec;
            end
            ST_BRANCH_ADDR:
            begin
                // Target is pc plus shifted offset
                alu_result_en = 1'b1;
                src_a         = SRC_A_PC;
                src_b         = SRC_B_IMM_SHIFT;
                alu_control   = ALU_ADD;
            end
            ST_BEQ_CMP, ST_BNE_CMP:
            begin
                rdx_en      = 1'b1;
                src_a       = SRC_A_REG;
                alu_control = ALU_SUB;
                pc_src      = PC_ALU_OUT;
                // Taken on equal for beq and on not equal for bne
                branch      = (state == ST_BEQ_CMP) ? zero : !zero;
            end
            ST_JUMP:
            begin
                pc_write = 1'b1;
                if (link)
                begin
                    // jal saves the return address in ra
                    reg_write  = 1'b1;
                    mem_to_reg = WB_PC;
                    reg_dst    = DST_RA;
                end
            end
            default:
            begin
                // IDLE, WAIT and UNDEFINED keep the defaults
            end
        endcase
    end

    assign pc_en = pc_write | branch;

endmodule

/* design/control_unit.sv */
`timescale 1ns/10ps
`include "mips_ctrl_consts.svh"

module control_unit
    import mips_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [`STEP_W-1:0] step,
    input  opcode_t            opcode,
    input  funct_t             funct,
    input  logic               zero,
    output logic               i_or_d,
    output logic               mem_write,
    output logic               mem_select,
    output logic               ir_write,
    output logic               data_write,
    output logic               reg_write,
    output logic               rdx_en,
    output logic               alu_result_en,
    output logic               pc_write,
    output logic               branch,
    output logic               pc_en,
    output alu_op_t            alu_control,
    output src_a_t             src_a,
    output src_b_t             src_b,
    output reg_dst_t           reg_dst,
    output wb_src_t            mem_to_reg,
    output pc_src_t            pc_src,
    output jump_kind_t         jump_kind
);

    // Decoder results
    instr_class_t instr_class;
    logic         is_store;
    alu_op_t      alu_op_dec;
    src_b_t       src_b_dec;
    reg_dst_t     reg_dst_dec;
    logic         link;
    // Sequencer state
    ctrl_state_t  state;

    instr_decoder u_instr_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class),
        .is_store    (is_store),
        .alu_op_dec  (alu_op_dec),
        .src_b_dec   (src_b_dec),
        .reg_dst_dec (reg_dst_dec),
        .link        (link),
        .jump_kind   (jump_kind)
    );

    ctrl_fsm u_ctrl_fsm (
        .clk         (clk),
        .reset       (reset),
        .step        (step),
        .instr_class (instr_class),
        .is_store    (is_store),
        .opcode      (opcode),
        .state       (state)
    );

    ctrl_outputs u_ctrl_outputs (
        .state         (state),
        .zero          (zero),
        .alu_op_dec    (alu_op_dec),
        .src_b_dec     (src_b_dec),
        .reg_dst_dec   (reg_dst_dec),
        .link          (link),
        .i_or_d        (i_or_d),
        .mem_write     (mem_write),
        .mem_select    (mem_select),
        .ir_write      (ir_write),
        .data_write    (data_write),
        .reg_write     (reg_write),
        .rdx_en        (rdx_en),
        .alu_result_en (alu_result_en),
        .pc_write      (pc_write),
        .branch        (branch),
        .pc_en         (pc_en),
        .alu_control   (alu_control),
        .src_a         (src_a),
        .src_b         (src_b),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .pc_src        (pc_src)
    );

endmodule

/* tb/tb_control_unit.sv */
`timescale 1ns/10ps
`include "mips_ctrl_consts.svh"

module tb_control_unit
    import mips_ctrl_pkg::*;
();

    logic               clk;
    logic               reset;
    logic [`STEP_W-1:0] step;
    opcode_t            opcode;
    funct_t             funct;
    logic               zero;
    logic               i_or_d;
    logic               mem_write;
    logic               mem_select;
    logic               ir_write;
    logic               data_write;
    logic               reg_write;
    logic               rdx_en;
    logic               alu_result_en;
    logic               pc_write;
    logic               branch;
    logic               pc_en;
    alu_op_t            alu_control;
    src_a_t             src_a;
    src_b_t             src_b;
    reg_dst_t           reg_dst;
    wb_src_t            mem_to_reg;
    pc_src_t            pc_src;
    jump_kind_t         jump_kind;

    // One entry per line of the input file
    string      name_q[$];
    opcode_t    op_q[$];
    funct_t     fn_q[$];
    logic       z_q[$];
    byte        path_q[$];
    alu_op_t    alu_q[$];
    src_b_t     sb_q[$];
    reg_dst_t   rd_q[$];
    jump_kind_t jk_q[$];

    // Expectations of the test in progress
    string       cur_name;
    alu_op_t     cur_alu;
    src_b_t      cur_sb;
    reg_dst_t    cur_rd;
    jump_kind_t  cur_jump;
    bit          tests_loaded = 1'b0;
    int          limit_ns;
    int unsigned rng_state = 46738;

    control_unit u_control_unit (
        .clk           (clk),
        .reset         (reset),
        .step          (step),
        .opcode        (opcode),
        .funct         (funct),
        .zero          (zero),
        .i_or_d        (i_or_d),
        .mem_write     (mem_write),
        .mem_select    (mem_select),
        .ir_write      (ir_write),
        .data_write    (data_write),
        .reg_write     (reg_write),
        .rdx_en        (rdx_en),
        .alu_result_en (alu_result_en),
        .pc_write      (pc_write),
        .branch        (branch),
        .pc_en         (pc_en),
        .alu_control   (alu_control),
        .src_a         (src_a),
        .src_b         (src_b),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .pc_src        (pc_src),
        .jump_kind     (jump_kind)
    );

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_bit(input string tag, input string sig, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("[ERROR] %s %s expected %0b actual %0b", tag, sig, exp, act);
            report_failure();
        end
    endtask

    task automatic check_alu(input string tag, input alu_op_t exp, input alu_op_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s alu_control expected %s actual %s", tag, exp.name(), act.name());
            report_failure();
        end
    endtask

    task automatic check_src_a(input string tag, input src_a_t exp, input src_a_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s src_a expected %s actual %s", tag, exp.name(), act.name());
            report_failure();
        end
    endtask

    task automatic check_src_b(input string tag, input src_b_t exp, input src_b_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s src_b expected %s actual %s", tag, exp.name(), act.name());
            report_failure();
        end
    endtask

    task automatic check_reg_dst(input string tag, input reg_dst_t exp, input reg_dst_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s reg_dst expected %s actual %s", tag, exp.name(), act.name());
            report_failure();
        end
    endtask

    task automatic check_wb(input string tag, input wb_src_t exp, input wb_src_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s mem_to_reg expected %s actual %s", tag, exp.name(), act.name());
            report_failure();
        end
    endtask

    task automatic check_pc_src(input string tag, input pc_src_t exp, input pc_src_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s pc_src expected %s actual %s", tag, exp.name(), act.name());
            report_failure();
        end
    endtask

    task automatic check_jump(input string tag, input jump_kind_t exp, input jump_kind_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s jump_kind expected %s actual %s", tag, exp.name(), act.name());
            report_failure();
        end
    endtask

    // LCG step with the upper bits as hold length
    function automatic int unsigned next_hold();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return ((rng_state >> 16) % 4) + 1;
    endfunction

    // State reached after step k for a given path letter
    function automatic ctrl_state_t path_state(input byte path, input int k);
        ctrl_state_t mid;
        ctrl_state_t last;
        ctrl_state_t result;
        case (path)
            "A":
            begin
                mid  = ST_EXECUTE;
                last = ST_WRITE_BACK;
            end
            "S":
            begin
                mid  = ST_EFF_ADDR;
                last = ST_STORE;
            end
            "L":
            begin
                mid  = ST_EFF_ADDR;
                last = ST_LOAD;
            end
            "Q":
            begin
                mid  = ST_BRANCH_ADDR;
                last = ST_BEQ_CMP;
            end
            "N":
            begin
                mid  = ST_BRANCH_ADDR;
                last = ST_BNE_CMP;
            end
            "J":
            begin
                mid  = ST_JUMP;
                last = ST_UPDATE_PC;
            end
            default:
            begin
                // Undefined passes through in one clock and looks idle
                mid  = ST_IDLE;
                last = ST_IDLE;
            end
        endcase
        case (k)
            1:       result = ST_FETCH;
            2:       result = ST_DECODE;
            3:       result = mid;
            4:       result = last;
            default: result = (path == "U") ? ST_IDLE : ST_WAIT;
        endcase
        return result;
    endfunction

    // Expected strobes and selectors for one state against the DUT
    task automatic verify_outputs(input string tag, input ctrl_state_t st);
        logic     e_iord, e_mw, e_msel, e_ir, e_dw, e_rw, e_rdx, e_are, e_pcw, e_br;
        alu_op_t  e_alu;
        src_a_t   e_sa;
        src_b_t   e_sb;
        reg_dst_t e_rd;
        wb_src_t  e_wb;
        pc_src_t  e_pcs;
        {e_iord, e_mw, e_msel, e_ir, e_dw, e_rw, e_rdx, e_are, e_pcw, e_br} = '0;
        e_alu = ALU_AND;
        e_sa  = SRC_A_PC;
        e_sb  = SRC_B_REG;
        e_rd  = DST_RT;
        e_wb  = WB_ALU;
        e_pcs = PC_ALU_RESULT;
        case (st)
            ST_FETCH:
            begin
                e_ir  = 1'b1;
                e_pcw = 1'b1;
                e_sb  = SRC_B_FOUR;
                e_alu = ALU_ADD;
            end
            ST_DECODE:
            begin
                e_rdx = 1'b1;
                e_sa  = SRC_A_REG;
                e_rd  = cur_rd;
                e_alu = cur_alu;
            end
            ST_EXECUTE:
            begin
                e_are = 1'b1;
                e_sa  = SRC_A_REG;
                e_sb  = cur_sb;
                e_alu = cur_alu;
                e_rd  = cur_rd;
            end
            ST_WRITE_BACK:
            begin
                e_rw = 1'b1;
                e_rd = cur_rd;
            end
            ST_EFF_ADDR:
            begin
                e_rdx = 1'b1;
                e_are = 1'b1;
                e_sa  = SRC_A_REG;
                e_sb  = SRC_B_IMM;
                e_alu = ALU_ADD;
            end
            ST_STORE:
            begin
                e_iord = 1'b1;
                e_mw   = 1'b1;
                e_msel = 1'b1;
            end
            ST_LOAD:
            begin
                e_iord = 1'b1;
                e_msel = 1'b1;
                e_dw   = 1'b1;
                e_rw   = 1'b1;
                e_wb   = WB_MEM;
                e_rd   = cur_rd;
            end
            ST_BRANCH_ADDR:
            begin
                e_are = 1'b1;
                e_sb  = SRC_B_IMM_SHIFT;
                e_alu = ALU_ADD;
            end
            ST_BEQ_CMP:
            begin
                e_rdx = 1'b1;
                e_sa  = SRC_A_REG;
                e_alu = ALU_SUB;
                e_pcs = PC_ALU_OUT;
                // beq is taken when the operands match
                e_br  = zero;
            end
            ST_BNE_CMP:
            begin
                e_rdx = 1'b1;
                e_sa  = SRC_A_REG;
                e_alu = ALU_SUB;
                e_pcs = PC_ALU_OUT;
                // bne is taken when the operands differ
                e_br  = ~zero;
            end
            ST_JUMP:
            begin
                e_pcw = 1'b1;
                // Link only for jal, recognised by its ra destination
                if (cur_rd == DST_RA)
                begin
                    e_rw = 1'b1;
                    e_wb = WB_PC;
                    e_rd = DST_RA;
                end
            end
            ST_UPDATE_PC:
            begin
                e_ir  = 1'b1;
                e_sb  = SRC_B_FOUR;
                e_alu = ALU_ADD;
            end
            default:
            begin
                // IDLE, WAIT and UNDEFINED drive nothing
            end
        endcase
        check_bit(tag, "i_or_d", e_iord, i_or_d);
        check_bit(tag, "mem_write", e_mw, mem_write);
        check_bit(tag, "mem_select", e_msel, mem_select);
        check_bit(tag, "ir_write", e_ir, ir_write);
        check_bit(tag, "data_write", e_dw, data_write);
        check_bit(tag, "reg_write", e_rw, reg_write);
        check_bit(tag, "rdx_en", e_rdx, rdx_en);
        check_bit(tag, "alu_result_en", e_are, alu_result_en);
        check_bit(tag, "pc_write", e_pcw, pc_write);
        check_bit(tag, "branch", e_br, branch);
        check_bit(tag, "pc_en", e_pcw | e_br, pc_en);
        check_alu(tag, e_alu, alu_control);
        check_src_a(tag, e_sa, src_a);
        check_src_b(tag, e_sb, src_b);
        check_reg_dst(tag, e_rd, reg_dst);
        check_wb(tag, e_wb, mem_to_reg);
        check_pc_src(tag, e_pcs, pc_src);
        check_jump(tag, cur_jump, jump_kind);
    endtask

    // Called on a falling edge to hold the step value for a random number of clocks
    task automatic run_step(input logic [`STEP_W-1:0] value, input ctrl_state_t st);
        int unsigned hold;
        hold = next_hold();
        step = value;
        repeat (hold)
        begin
            @(negedge clk);
            verify_outputs($sformatf("%s step %0d", cur_name, value), st);
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          cnt;
        string       line;
        string       t_name;
        string       t_path;
        int unsigned v_op, v_fn, v_z, v_alu, v_sb, v_rd, v_jk;
        fd = $fopen("tb/control_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the input file tb/control_input.txt");
            report_failure();
        end
        while ($fgets(line, fd) != 0)
        begin
            // Skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                cnt = $sscanf(line, "%s %h %h %h %s %h %h %h %h", t_name, v_op, v_fn, v_z,
                              t_path, v_alu, v_sb, v_rd, v_jk);
                if (cnt != 9)
                begin
                    $display("Malformed line in the input file: %s", line);
                    report_failure();
                end
                name_q.push_back(t_name);
                op_q.push_back(opcode_t'(v_op[5:0]));
                fn_q.push_back(funct_t'(v_fn[5:0]));
                z_q.push_back(v_z[0]);
                path_q.push_back(t_path.getc(0));
                alu_q.push_back(alu_op_t'(v_alu[3:0]));
                sb_q.push_back(src_b_t'(v_sb[1:0]));
                rd_q.push_back(reg_dst_t'(v_rd[1:0]));
                jk_q.push_back(jump_kind_t'(v_jk[1:0]));
            end
        end
        $fclose(fd);
        if (name_q.size() == 0)
        begin
            $display("The input file holds no tests");
            report_failure();
        end
    endtask

    // Watchdog sized from the number of tests
    initial
    begin
        wait (tests_loaded);
        limit_ns = name_q.size() * 6 * 4 * 4 + 200;
        #(limit_ns);
        $display("Watchdog expired after %0d ns before all tests finished", limit_ns);
        report_failure();
    end

    initial
    begin
        reset    = 1'b0;
        step     = '0;
        opcode   = OP_RTYPE;
        funct    = FN_ADD;
        zero     = 1'b0;
        cur_name = "reset";
        cur_alu  = ALU_AND;
        cur_sb   = SRC_B_REG;
        cur_rd   = DST_RT;
        cur_jump = JMP_NONE;
        load_tests();
        tests_loaded = 1'b1;

        // Reset held for three clocks with all strobes idle
        repeat (3)
        begin
            @(negedge clk);
            verify_outputs("reset", ST_IDLE);
        end
        reset = 1'b1;

        // Step 0 keeps the unit idle
        cur_name = "idle";
        repeat (3)
        begin
            @(negedge clk);
            verify_outputs("idle after reset", ST_IDLE);
        end

        for (int i = 0; i < name_q.size(); i++)
        begin
            // New instruction applied while parked in IDLE or WAIT
            cur_name = name_q[i];
            cur_alu  = alu_q[i];
            cur_sb   = sb_q[i];
            cur_rd   = rd_q[i];
            cur_jump = jk_q[i];
            opcode   = op_q[i];
            funct    = fn_q[i];
            zero     = z_q[i];
            step     = '0;
            @(negedge clk);
            verify_outputs($sformatf("%s parked", cur_name), ST_IDLE);
            for (int k = 1; k <= 5; k++)
            begin
                run_step(3'(k), path_state(path_q[i], k));
            end
        end

        // Back to step 1 starts a new fetch
        run_step(`STEP_FETCH, ST_FETCH);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tb/control_input.txt */
# name opcode funct zero path alu_op src_b reg_dst jump_kind, numbers in hex
# path A alu, S store, L load, Q beq, N bne, J jump, U undefined
add      00 20 0 A 2 0 1 0
sub      00 22 0 A 1 0 1 0
and      00 24 1 A 0 0 1 0
or       00 25 0 A 3 0 1 0
slt      00 2a 0 A 4 0 1 0
addi     08 00 0 A 2 2 0 0
slti     0a 3f 0 A 4 2 0 0
andi     0c 00 1 A 0 2 0 0
ori      0d 25 0 A 3 2 0 0
lui      0f 00 0 A 5 2 0 0
sw       2b 00 0 S 2 2 0 0
lw       23 00 1 L 2 2 0 0
sw_z     2b 20 1 S 2 2 0 0
lw_z     23 2a 0 L 2 2 0 0
beq_tk   04 00 1 Q 1 0 0 0
beq_nt   04 00 0 Q 1 0 0 0
bne_tk   05 00 0 N 1 0 0 0
bne_nt   05 00 1 N 1 0 0 0
j        02 00 0 J 0 0 0 1
jr       00 08 0 J 0 0 1 2
jal      03 00 0 J 0 0 2 3
bad_op3f 3f 00 0 U 0 0 0 0
add_2    00 20 1 A 2 0 1 0
bad_fn01 00 01 0 U 0 0 1 0
lw_2     23 00 0 L 2 2 0 0
bad_op01 01 20 1 U 0 0 0 0
jal_2    03 3f 1 J 0 0 2 3
bad_fn0c 00 0c 0 U 0 0 1 0
beq_2    04 20 1 Q 1 0 0 0
bad_op2a 2a 00 0 U 0 0 0 0
bne_2    05 00 0 N 1 0 0 0
jr_2     00 08 1 J 0 0 1 2
slt_2    00 2a 1 A 4 0 1 0
lui_2    0f 3f 1 A 5 2 0 0

/* sim.f */
+incdir+design
design/mips_ctrl_pkg.sv
design/instr_decoder.sv
design/ctrl_fsm.sv
design/ctrl_outputs.sv
design/control_unit.sv
tb/tb_control_unit.sv

/* Makefile */
TOP = tb_control_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps -f sim.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
